// ==== tb.f ====
src/cpuPkg.sv
src/cpuControl.sv
src/programCounter.sv
src/busMaster.sv
src/accumulatorUnit.sv
src/cpuTop.sv
tb/wishbone_asserts.sv
tb/cpuTb.sv

// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert
TOP      := cpuTb
FILELIST := tb.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(TOOL), run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "^Verification passed$$" $(LOG); then \
		echo "Simulation PASS"; \
	else \
		echo "Simulation FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// ==== tb/cpuTb.sv ====
/*
 * Testbench for the accumulator processor. Each table entry becomes a short
 * program in a Wishbone memory model; the DUT runs it to HLT or a trap and
 * the stored bytes are checked. The table runs twice, the second time with random waits.
 */
`default_nettype none

module cpuTb import cpuPkg::*; ();

	localparam int numTests = 30;
	localparam logic [15:0] resultAddr = 16'h8000;
	localparam logic [15:0] carryAddr = 16'h8001;

	typedef struct packed {
		logic [7:0] op;
		logic [7:0] a;
		logic [7:0] b;
		logic rnd; // Operands drawn from the LFSR
		logic [7:0] expRes;
		logic expCarry;
		logic trap;
	} testT;

	logic CLK;
	logic rstN = 1'b0;
	wbReqT wbReq;
	wbRspT wbRsp = '0;
	logic halted;
	logic badOpcode;

	logic [7:0] mem [0:65535];
	logic [15:0] ptr;
	logic [31:0] lfsr = 32'hf8cd_5e56;
	logic useWaits = 1'b0;
	logic pending = 1'b0;
	logic [15:0] waitLeft = '0;
	int checks = 0;
	int errors = 0;

	// Branch entries store a5 when taken, 5a when not
	testT tests [0:numTests-1] = '{
		'{opAddImm, 8'h7f, 8'h81, 1'b0, 8'h00, 1'b1, 1'b0},
		'{opAddImm, 8'h12, 8'h34, 1'b0, 8'h46, 1'b0, 1'b0},
		'{opAddImm, 8'h00, 8'h00, 1'b1, 8'h00, 1'b0, 1'b0},
		'{opSubImm, 8'h10, 8'h20, 1'b0, 8'hf0, 1'b1, 1'b0},
		'{opSubImm, 8'h00, 8'h00, 1'b1, 8'h00, 1'b0, 1'b0},
		'{opAndImm, 8'hf0, 8'h3c, 1'b0, 8'h30, 1'b0, 1'b0},
		'{opOraImm, 8'hf0, 8'h0c, 1'b0, 8'hfc, 1'b0, 1'b0},
		'{opLdaAbs, 8'h00, 8'h9c, 1'b0, 8'h9c, 1'b0, 1'b0},
		'{opAddAbs, 8'hc8, 8'h64, 1'b0, 8'h2c, 1'b1, 1'b0},
		'{opSubAbs, 8'h40, 8'h01, 1'b0, 8'h3f, 1'b0, 1'b0},
		'{opSubAbs, 8'h00, 8'h00, 1'b1, 8'h00, 1'b0, 1'b0},
		'{opAndAbs, 8'h00, 8'h00, 1'b1, 8'h00, 1'b0, 1'b0},
		'{opOraAbs, 8'h00, 8'h00, 1'b1, 8'h00, 1'b0, 1'b0},
		'{opCla, 8'h55, 8'h00, 1'b0, 8'h00, 1'b0, 1'b0},
		'{opIna, 8'hff, 8'h00, 1'b0, 8'h00, 1'b1, 1'b0},
		'{opIna, 8'h00, 8'h00, 1'b1, 8'h00, 1'b0, 1'b0},
		'{opDca, 8'h00, 8'h00, 1'b0, 8'hff, 1'b1, 1'b0},
		'{opCpa, 8'h5a, 8'h00, 1'b0, 8'ha5, 1'b0, 1'b0},
		'{opClc, 8'h33, 8'h00, 1'b0, 8'h33, 1'b0, 1'b0},
		'{opSec, 8'h33, 8'h00, 1'b0, 8'h33, 1'b1, 1'b0},
		'{opNop, 8'h77, 8'h00, 1'b0, 8'h77, 1'b0, 1'b0},
		'{opBeq, 8'h80, 8'h80, 1'b0, 8'ha5, 1'b1, 1'b0},
		'{opBne, 8'h80, 8'h80, 1'b0, 8'h5a, 1'b1, 1'b0},
		'{opBcc, 8'h01, 8'h02, 1'b0, 8'ha5, 1'b0, 1'b0},
		'{opBcs, 8'h01, 8'h02, 1'b0, 8'h5a, 1'b0, 1'b0},
		'{opBeq, 8'h00, 8'h00, 1'b1, 8'h00, 1'b0, 1'b0},
		'{opBne, 8'h00, 8'h00, 1'b1, 8'h00, 1'b0, 1'b0},
		'{opBcs, 8'h00, 8'h00, 1'b1, 8'h00, 1'b0, 1'b0},
		'{opHlt, 8'h21, 8'h00, 1'b0, 8'h00, 1'b0, 1'b0},
		'{8'h77, 8'h21, 8'h00, 1'b0, 8'h00, 1'b0, 1'b1} // Undefined opcode
	};

	cpuTop #(.dataWidth(dataWidth), .addrWidth(addrWidth)) uut (
		.CLK(CLK), .rstN(rstN), .wbReq(wbReq), .wbRsp(wbRsp),
		.halted(halted), .badOpcode(badOpcode)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	function automatic logic [31:0] lfsrStep(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function logic [15:0] randomBits(int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], lfsr[0]};
			lfsr = lfsrStep(lfsr);
		end
		return v;
	endfunction

	function automatic logic [7:0] fillByte(logic [15:0] adr);
		return adr[15:8] ^ adr[7:0] ^ 8'h3c;
	endfunction

	// Memory model with 0 to 3 wait states in the second pass
	always @(negedge CLK) begin
		if (wbRsp.ack) begin
			wbRsp.ack = 1'b0;
			pending = 1'b0;
		end else if (wbReq.cyc && wbReq.stb) begin
			if (!pending) begin
				pending = 1'b1;
				waitLeft = useWaits ? randomBits(2) : 16'd0;
			end
			if (waitLeft == 16'd0) begin
				if (wbReq.we)
					mem[wbReq.adr] = wbReq.dat;
				else
					wbRsp.dat = mem[wbReq.adr];
				wbRsp.ack = 1'b1;
			end else begin
				waitLeft = waitLeft - 16'd1;
			end
		end
	end

	task automatic expectEqual(input string what, input logic [7:0] got,
			input logic [7:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("error at %0t: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic expectedFor(input logic [7:0] op, input logic [7:0] a,
			input logic [7:0] b, output logic [7:0] res, output logic carry);
		logic [8:0] sum;
		logic taken;
		sum = {1'b0, a} + {1'b0, b};
		taken = 1'b0;
		res = a;
		carry = 1'b0; // Clear from reset or CLC
		case (op)
			opLdaImm, opLdaAbs: res = b;
			opAddImm, opAddAbs: {carry, res} = sum;
			opSubImm, opSubAbs: begin
				res = a - b;
				carry = (a < b);
			end
			opAndImm, opAndAbs: res = a & b;
			opOraImm, opOraAbs: res = a | b;
			opCla: res = 8'h00;
			opIna: begin
				res = a + 8'd1;
				carry = (a == 8'hff);
			end
			opDca: begin
				res = a - 8'd1;
				carry = (a == 8'h00);
			end
			opCpa: res = ~a;
			opSec: carry = 1'b1;
			opBeq: taken = (sum[7:0] == 8'h00);
			opBne: taken = (sum[7:0] != 8'h00);
			opBcc: taken = !sum[8];
			opBcs: taken = sum[8];
			default: res = a;
		endcase
		if (op inside {opBeq, opBne, opBcc, opBcs}) begin
			carry = sum[8];
			res = taken ? 8'ha5 : 8'h5a;
		end
	endtask

	task automatic putByte(input logic [7:0] v);
		mem[ptr] = v;
		ptr = ptr + 16'd1;
	endtask

	task automatic putImmediate(input logic [7:0] op, input logic [7:0] v);
		putByte(op);
		putByte(v);
	endtask

	task automatic putAbsolute(input logic [7:0] op, input logic [15:0] adr);
		putByte(op);
		putByte(adr[7:0]); // Low byte first
		putByte(adr[15:8]);
	endtask

	task automatic writeProgram(input logic [7:0] op, input logic [7:0] a,
			input logic [7:0] b);
		logic [15:0] r;
		logic [15:0] operandAt;
		ptr = 16'h0000;
		if (op inside {opBeq, opBne, opBcc, opBcs}) begin
			putAbsolute(opJmpAbs, 16'h0020);
			putImmediate(opLdaImm, 8'ha5); // Taken path at 0003
			putAbsolute(opJmpAbs, 16'h0040);
			ptr = 16'h0020;
			putImmediate(opLdaImm, a);
			putImmediate(opAddImm, b);
			putImmediate(op, 8'hdd); // 0026 - 23h = 0003
			putImmediate(opLdaImm, 8'h5a);
			putAbsolute(opJmpAbs, 16'h0040);
			ptr = 16'h0040;
		end else begin
			putImmediate(opLdaImm, a);
			case (op)
				opLdaAbs, opAddAbs, opSubAbs, opAndAbs, opOraAbs: begin
					r = randomBits(12);
					operandAt = {4'h1, r[11:0]};
					mem[operandAt] = b;
					putAbsolute(op, operandAt);
				end
				opLdaImm, opAddImm, opSubImm, opAndImm, opOraImm: putImmediate(op, b);
				default: begin
					if (op == opClc)
						putByte(opSec); // Carry set for CLC to clear
					putByte(op);
				end
			endcase
		end
		putAbsolute(opStaAbs, resultAddr);
		putImmediate(opBcs, 8'h06); // Forward over the carry-clear path
		putImmediate(opLdaImm, 8'h00);
		putAbsolute(opStaAbs, carryAddr);
		putByte(opHlt);
		putImmediate(opLdaImm, 8'h01);
		putAbsolute(opStaAbs, carryAddr);
		putByte(opHlt);
	endtask

	task automatic runEntry(input testT t, input int index);
		logic [15:0] r;
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] expRes;
		logic expCarry;
		logic stops;
		logic [16:0] adr;
		string tag;
		a = t.a;
		b = t.b;
		expRes = t.expRes;
		expCarry = t.expCarry;
		if (t.rnd) begin
			r = randomBits(16);
			a = r[15:8];
			b = r[7:0];
			expectedFor(t.op, a, b, expRes, expCarry);
		end
		for (adr = 17'd0; adr < 17'h10000; adr++)
			mem[adr[15:0]] = fillByte(adr[15:0]);
		writeProgram(t.op, a, b);
		@(negedge CLK);
		rstN = 1'b0;
		repeat (10) @(negedge CLK);
		rstN = 1'b1;
		while (!halted && !badOpcode)
			@(negedge CLK);
		tag = $sformatf("entry %0d (waits %0d, a %h, b %h)", index, useWaits, a, b);
		stops = t.trap || (t.op == opHlt);
		expectEqual({tag, " halted"}, 8'(halted), 8'(!t.trap));
		expectEqual({tag, " badOpcode"}, 8'(badOpcode), 8'(t.trap));
		if (stops) begin
			expectEqual({tag, " untouched result"}, mem[resultAddr], fillByte(resultAddr));
			expectEqual({tag, " untouched marker"}, mem[carryAddr], fillByte(carryAddr));
		end else begin
			expectEqual({tag, " result"}, mem[resultAddr], expRes);
			expectEqual({tag, " carry marker"}, mem[carryAddr], {7'b0, expCarry});
		end
	endtask

	initial begin
		for (int pass = 0; pass < 2; pass++) begin
			useWaits = (pass == 1);
			for (int i = 0; i < numTests; i++)
				runEntry(tests[i], i);
		end
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	// Watchdog over both passes of the table
	initial begin
		repeat (numTests * 400) @(posedge CLK);
		$display("Timeout: the processor never halted within %0d cycles", numTests * 400);
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/wishbone_asserts.sv ====
/*
 * Wishbone classic handshake checks, bound into the bus master.
 * Failures show up as assertion errors in the simulation log.
 */
`default_nettype none

module wishboneAsserts import cpuPkg::*; (
	input logic CLK,
	input logic rstN,
	input wbReqT wbReq,
	input wbRspT wbRsp
);

	stbNeedsCyc: assert property (@(posedge CLK) wbReq.stb |-> wbReq.cyc)
		else $error("stb high without cyc");

	// Request frozen until the slave answers
	holdUntilAck: assert property (@(posedge CLK) disable iff (!rstN)
		(wbReq.stb && !wbRsp.ack) |=> (wbReq.stb && $stable(wbReq.adr) &&
		$stable(wbReq.we) && $stable(wbReq.dat)))
		else $error("request changed before ack");

	dropAfterAck: assert property (@(posedge CLK) disable iff (!rstN)
		(wbReq.stb && wbRsp.ack) |=> !wbReq.cyc)
		else $error("cyc still high after ack");

	idleAfterReset: assert property (@(posedge CLK) !rstN |=> !wbReq.cyc)
		else $error("cyc high after reset");

endmodule

bind busMaster wishboneAsserts wbChecks (
	.CLK(CLK), .rstN(rstN), .wbReq(wbReq), .wbRsp(wbRsp)
);

`default_nettype wire

// ==== src/cpuTop.sv ====
/*
 * Processor top level. Wires the control FSM, program counter, bus master
 * and accumulator together behind one Wishbone classic master port.
 */
`default_nettype none

module cpuTop import cpuPkg::*; #(
	parameter int dataWidth = cpuPkg::dataWidth,
	parameter int addrWidth = cpuPkg::addrWidth
) (
	input logic CLK,
	input logic rstN,
	output wbReqT wbReq,
	input wbRspT wbRsp,
	output logic halted,
	output logic badOpcode
);

	busCmdT busCmd;
	pcCtrlT pcCtrl;
	aluOpT aluOp;
	opcodeT instr;
	flagsT flags;
	logic latchLow;
	logic loadInstr;
	logic done;
	logic [dataWidth-1:0] rdData;
	logic [dataWidth-1:0] acc;
	logic [addrWidth-1:0] pc;
	logic [addrWidth-1:0] operandAddr;

	cpuControl control (
		.CLK(CLK), .rstN(rstN), .instr(instr), .flags(flags), .done(done),
		.busCmd(busCmd), .latchLow(latchLow), .pcCtrl(pcCtrl), .aluOp(aluOp),
		.loadInstr(loadInstr), .halted(halted), .badOpcode(badOpcode)
	);

	programCounter #(.addrWidth(addrWidth), .dataWidth(dataWidth)) counter (
		.CLK(CLK), .rstN(rstN), .pcCtrl(pcCtrl), .operandAddr(operandAddr),
		.offset(rdData), .pc(pc)
	);

	busMaster #(.dataWidth(dataWidth), .addrWidth(addrWidth)) master (
		.CLK(CLK), .rstN(rstN), .busCmd(busCmd), .pc(pc), .acc(acc),
		.latchLow(latchLow), .wbReq(wbReq), .wbRsp(wbRsp), .done(done),
		.rdData(rdData), .operandAddr(operandAddr)
	);

	accumulatorUnit #(.dataWidth(dataWidth)) accumulator (
		.CLK(CLK), .rstN(rstN), .aluOp(aluOp), .loadInstr(loadInstr),
		.rdData(rdData), .instr(instr), .acc(acc), .flags(flags)
	);

endmodule

`default_nettype wire

// ==== src/accumulatorUnit.sv ====
/*
 * Instruction register, accumulator and flags.
 * Applies one accumulator action per cycle; flags change with the
 * accumulator in the same cycle.
 */
`default_nettype none

module accumulatorUnit import cpuPkg::*; #(
	parameter int dataWidth = cpuPkg::dataWidth
) (
	input logic CLK,
	input logic rstN,
	input aluOpT aluOp,
	input logic loadInstr,
	input logic [dataWidth-1:0] rdData,
	output opcodeT instr,
	output logic [dataWidth-1:0] acc,
	output flagsT flags
);

	logic [dataWidth-1:0] operand;
	logic [dataWidth:0] sumWide;
	logic [dataWidth:0] diffWide;
	logic [dataWidth-1:0] result;
	logic carryNext;

	// INA and DCA share the adder with a constant one
	assign operand = (aluOp == inc || aluOp == dec) ? dataWidth'(1) : rdData;
	assign sumWide = {1'b0, acc} + {1'b0, operand};
	assign diffWide = {1'b0, acc} - {1'b0, operand}; // Top bit is the borrow

	always_comb begin
		result = acc;
		carryNext = flags.carry;
		case (aluOp)
			load: result = rdData;
			add, inc: begin
				result = sumWide[dataWidth-1:0];
				carryNext = sumWide[dataWidth];
			end
			sub, dec: begin
				result = diffWide[dataWidth-1:0];
				carryNext = diffWide[dataWidth];
			end
			andOp: result = acc & rdData;
			orOp: result = acc | rdData;
			clear: result = '0;
			complement: result = ~acc;
			clearCarry: carryNext = 1'b0;
			setCarry: carryNext = 1'b1;
			default: result = acc;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			instr <= opNop;
			acc <= '0;
			flags <= '0;
		end else begin
			if (loadInstr)
				instr <= opcodeT'(rdData);
			if (aluOp != hold) begin
				acc <= result;
				flags <= '{carry: carryNext, zero: (result == '0),
					negative: result[dataWidth-1]};
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/busMaster.sv ====
/*
 * Wishbone classic master. Runs one access per start command, holds the
 * request stable until ack, latches the read byte and builds the
 * operand address from the captured low byte and the last byte read.
 */
`default_nettype none

module busMaster import cpuPkg::*; #(
	parameter int dataWidth = cpuPkg::dataWidth,
	parameter int addrWidth = cpuPkg::addrWidth
) (
	input logic CLK,
	input logic rstN,
	input busCmdT busCmd,
	input logic [addrWidth-1:0] pc,
	input logic [dataWidth-1:0] acc,
	input logic latchLow,
	output wbReqT wbReq,
	input wbRspT wbRsp,
	output logic done,
	output logic [dataWidth-1:0] rdData,
	output logic [addrWidth-1:0] operandAddr
);

	logic active; // Drives both cyc and stb
	logic weReg;
	logic [addrWidth-1:0] adrReg;
	logic [dataWidth-1:0] datReg;
	logic [dataWidth-1:0] lowByte;
	logic finish;

	assign finish = active && wbRsp.ack;

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			active <= 1'b0;
			weReg <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= finish;
			if (busCmd.start) begin
				active <= 1'b1;
				weReg <= busCmd.write;
			end else if (finish) begin
				active <= 1'b0;
				weReg <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (busCmd.start) begin
			adrReg <= (busCmd.addrSel == fromOperand) ? operandAddr : pc;
			datReg <= acc;
		end
		if (finish)
			rdData <= wbRsp.dat;
		if (latchLow)
			lowByte <= rdData;
	end

	// High byte is whatever was read last
	assign operandAddr = addrWidth'({rdData, lowByte});

	assign wbReq = '{cyc: active, stb: active, we: weReg, adr: adrReg, dat: datReg};

endmodule

`default_nettype wire

// ==== src/programCounter.sv ====
/*
 * Program counter. Steps past each fetched byte, loads absolute jump
 * targets and adds signed branch offsets.
 */
`default_nettype none

module programCounter import cpuPkg::*; #(
	parameter int addrWidth = cpuPkg::addrWidth,
	parameter int dataWidth = cpuPkg::dataWidth
) (
	input logic CLK,
	input logic rstN,
	input pcCtrlT pcCtrl,
	input logic [addrWidth-1:0] operandAddr,
	input logic [dataWidth-1:0] offset,
	output logic [addrWidth-1:0] pc
);

	logic [addrWidth-1:0] nextPc;
	logic [addrWidth-1:0] offsetExt;
	logic [addrWidth-1:0] branchTarget;

	assign nextPc = pc + addrWidth'(1);

	// Offset counts from the byte after itself
	assign offsetExt = {{(addrWidth-dataWidth){offset[dataWidth-1]}}, offset};
	assign branchTarget = nextPc + offsetExt;

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			pc <= '0;
		end else if (pcCtrl.branch) begin
			pc <= branchTarget;
		end else if (pcCtrl.loadAbsolute) begin
			pc <= operandAddr;
		end else if (pcCtrl.increment) begin
			pc <= nextPc;
		end
	end

endmodule

`default_nettype wire

// ==== src/cpuControl.sv ====
/*
 * Instruction state machine. Walks fetch, decode, operand and data cycles,
 * issues one bus command per access and steers the counter and accumulator.
 */
`default_nettype none

module cpuControl import cpuPkg::*; (
	input logic CLK,
	input logic rstN,
	input opcodeT instr,
	input flagsT flags,
	input logic done,
	output busCmdT busCmd,
	output logic latchLow,
	output pcCtrlT pcCtrl,
	output aluOpT aluOp,
	output logic loadInstr,
	output logic halted,
	output logic badOpcode
);

	stateT state, nextState;
	busCmdT cmdNext;

	function automatic aluOpT aluFor(opcodeT op);
		case (op)
			opLdaImm, opLdaAbs: return load;
			opAddImm, opAddAbs: return add;
			opSubImm, opSubAbs: return sub;
			opAndImm, opAndAbs: return andOp;
			opOraImm, opOraAbs: return orOp;
			opCla: return clear;
			opIna: return inc;
			opDca: return dec;
			opCpa: return complement;
			opClc: return clearCarry;
			opSec: return setCarry;
			default: return hold; // NOP and STA leave acc alone
		endcase
	endfunction

	function automatic logic branchTaken(opcodeT op, flagsT f);
		case (op)
			opBeq: return f.zero;
			opBne: return !f.zero;
			opBcc: return !f.carry;
			opBcs: return f.carry;
			default: return 1'b0;
		endcase
	endfunction

	always_comb begin
		nextState = state;
		aluOp = hold;
		loadInstr = 1'b0;
		latchLow = 1'b0;
		pcCtrl = '0;
		case (state)
			stFetch: if (done) begin
				loadInstr = 1'b1;
				pcCtrl.increment = 1'b1;
				nextState = stDecode;
			end
			stDecode: case (instr)
				opLdaImm, opAddImm, opSubImm, opAndImm, opOraImm,
				opBeq, opBne, opBcc, opBcs,
				opLdaAbs, opAddAbs, opSubAbs, opAndAbs, opOraAbs,
				opStaAbs, opJmpAbs: nextState = stOperandLow;
				opNop, opCla, opIna, opDca, opCpa, opClc, opSec: nextState = stExecute;
				opHlt: nextState = stHalted;
				default: nextState = stTrapped;
			endcase
			stOperandLow: if (done) begin
				case (instr)
					opLdaAbs, opAddAbs, opSubAbs, opAndAbs, opOraAbs,
					opStaAbs, opJmpAbs: begin
						latchLow = 1'b1; // Low address byte first
						pcCtrl.increment = 1'b1;
						nextState = stOperandHigh;
					end
					opBeq, opBne, opBcc, opBcs: begin
						pcCtrl.branch = branchTaken(instr, flags);
						pcCtrl.increment = !branchTaken(instr, flags);
						nextState = stFetch;
					end
					default: begin
						aluOp = aluFor(instr); // Immediate operand in rdData
						pcCtrl.increment = 1'b1;
						nextState = stFetch;
					end
				endcase
			end
			stOperandHigh: if (done) begin
				if (instr == opJmpAbs) begin
					pcCtrl.loadAbsolute = 1'b1;
					nextState = stFetch;
				end else begin
					pcCtrl.increment = 1'b1;
					nextState = stDataAccess;
				end
			end
			stDataAccess: if (done) begin
				aluOp = aluFor(instr);
				nextState = stFetch;
			end
			stExecute: begin
				aluOp = aluFor(instr);
				nextState = stFetch;
			end
			stHalted, stTrapped: nextState = state; // Wait for reset
			default: nextState = stTrapped;
		endcase
	end

	// Command goes out the cycle a bus state is entered
	always_comb begin
		cmdNext.start = (nextState != state) && (nextState == stFetch ||
			nextState == stOperandLow || nextState == stOperandHigh ||
			nextState == stDataAccess);
		cmdNext.write = (nextState == stDataAccess) && (instr == opStaAbs);
		cmdNext.addrSel = (nextState == stDataAccess) ? fromOperand : fromPc;
	end

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			state <= stExecute; // Runs the reset NOP, then fetches
			busCmd <= '0;
		end else begin
			state <= nextState;
			busCmd <= cmdNext;
		end
	end

	assign halted = (state == stHalted);
	assign badOpcode = (state == stTrapped);

endmodule

`default_nettype wire

// ==== src/cpuPkg.sv ====
/*
 * Shared types for the accumulator processor.
 * Holds the bus structs, the opcode and state encodings and the default widths.
 * Every design file imports what it needs from here.
 */
`default_nettype none

package cpuPkg;

	parameter int dataWidth = 8;
	parameter int addrWidth = 16;

	// Fixed encodings; the addressing mode is part of the name
	typedef enum logic [7:0] {
		opNop    = 8'h00,
		opLdaImm = 8'h10,
		opAddImm = 8'h11,
		opSubImm = 8'h12,
		opAndImm = 8'h13,
		opOraImm = 8'h14,
		opLdaAbs = 8'h20,
		opAddAbs = 8'h21,
		opSubAbs = 8'h22,
		opAndAbs = 8'h23,
		opOraAbs = 8'h24,
		opStaAbs = 8'h25,
		opJmpAbs = 8'h26,
		opCla    = 8'h30,
		opIna    = 8'h31,
		opDca    = 8'h32,
		opCpa    = 8'h33,
		opClc    = 8'h34,
		opSec    = 8'h35,
		opBeq    = 8'h40,
		opBne    = 8'h41,
		opBcc    = 8'h42,
		opBcs    = 8'h43,
		opHlt    = 8'hff
	} opcodeT;

	typedef enum logic [2:0] {
		stFetch, stDecode, stOperandLow, stOperandHigh,
		stDataAccess, stExecute, stHalted, stTrapped
	} stateT;

	typedef enum logic [3:0] {
		hold, load, add, sub, andOp, orOp,
		clear, inc, dec, complement, clearCarry, setCarry
	} aluOpT;

	typedef enum logic [1:0] {fromPc, fromOperand} addrSelT;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [addrWidth-1:0] adr;
		logic [dataWidth-1:0] dat;
	} wbReqT;

	typedef struct packed {
		logic ack;
		logic [dataWidth-1:0] dat;
	} wbRspT;

	typedef struct packed {
		logic start; // One-cycle pulse
		logic write;
		addrSelT addrSel;
	} busCmdT;

	typedef struct packed {
		logic increment;
		logic loadAbsolute;
		logic branch;
	} pcCtrlT;

	typedef struct packed {
		logic carry;
		logic zero;
		logic negative;
	} flagsT;

endpackage

`default_nettype wire
